// ==== common/srpt_pkg.sv ====
`default_nettype none

package srpt_pkg;

   // Identifiers shared by headers, queue entries and grants
   typedef logic [13:0] peer_id_t;
   typedef logic [13:0] rpc_id_t;

   // Bytes of a message still to be granted
   typedef logic [9:0] grantable_t;

   // Stored priority of an entry, or the command a pushed entry carries
   typedef logic [2:0] prio_t;

   // Command codes sit below every stored code
   // A pushed command therefore always sinks through the queue
   localparam prio_t prio_update       = 3'd0;
   localparam prio_t prio_update_block = 3'd1;
   localparam prio_t prio_invalidate   = 3'd2;
   localparam prio_t prio_unblock      = 3'd3;

   // Stored codes, higher sorts toward the head
   localparam prio_t prio_empty        = 3'd4;
   localparam prio_t prio_blocked      = 3'd5;
   localparam prio_t prio_active       = 3'd6;

   // One queue entry, 41 bits
   typedef struct packed {
      peer_id_t   peer;
      rpc_id_t    rpc;
      grantable_t grantable;
      prio_t      prio;
   } entry_t;

   // Value of an unused queue position or free slot
   localparam entry_t empty_entry = '{peer: '0, rpc: '0, grantable: '0, prio: prio_empty};

   // Entries per queue and size of the active set
   localparam int unsigned queue_depth = 16;
   localparam int unsigned num_slots   = 4;

   typedef logic [$clog2(num_slots)-1:0] slot_idx_t;

endpackage

`default_nettype wire

// ==== common/hdr_pkg.sv ====
`default_nettype none

package hdr_pkg;

   import srpt_pkg::*;

   // Message length and byte counts in a data header
   typedef logic [9:0] msg_len_t;

   // Head word of the incoming header FIFO, 80 bits
   typedef struct packed {
      peer_id_t    peer;
      rpc_id_t     rpc;
      msg_len_t    msg_len;
      // Bytes already received or in flight
      msg_len_t    incoming;
      // Zero marks the first unscheduled packet
      logic [31:0] offset;
   } hdr_t;

endpackage

`default_nettype wire

// ==== srpt_queue/srpt_swap_cell.sv ====
`timescale 1ns/1ps
`default_nettype none

module srpt_swap_cell (
   input  wire srpt_pkg::entry_t upper_i,
   input  wire srpt_pkg::entry_t lower_i,
   output srpt_pkg::entry_t      upper_o,
   output srpt_pkg::entry_t      lower_o
);

   import srpt_pkg::*;

   // Upper entry belongs below the lower one
   logic   ranks_below_c;
   logic   same_peer_c;
   logic   same_rpc_c;
   // Lower entry after the upper one's command has been applied
   entry_t merged_c;

   // Higher code wins, fewer grantable bytes break a tie
   assign ranks_below_c = (upper_i.prio != lower_i.prio) ?
                          (upper_i.prio < lower_i.prio) :
                          (upper_i.grantable > lower_i.grantable);

   assign same_peer_c = (upper_i.peer == lower_i.peer);
   assign same_rpc_c  = same_peer_c && (upper_i.rpc == lower_i.rpc);

   // Command merge as the upper entry passes the lower one
   always_comb begin
      merged_c = lower_i;
      if ((upper_i.prio == prio_update_block) && same_rpc_c) begin
         // The granted RPC itself, take the new byte count
         merged_c.grantable = upper_i.grantable;
         merged_c.prio      = prio_blocked;
      end else if ((upper_i.prio == prio_update_block) && same_peer_c) begin
         // Other RPCs of a peer that now holds a slot
         merged_c.prio = prio_blocked;
      end else if ((upper_i.prio == prio_unblock) && same_peer_c) begin
         // Peer left the active set, all its RPCs compete again
         merged_c.prio = prio_active;
      end else if ((upper_i.prio == prio_invalidate) && same_rpc_c) begin
         // Message complete
         merged_c.prio = prio_empty;
      end
   end

   // Swapped pair keeps the lower peer and rpc in the upper position
   assign upper_o = ranks_below_c ? merged_c : upper_i;
   assign lower_o = ranks_below_c ? upper_i : lower_i;

endmodule

`default_nettype wire

// ==== srpt_queue/srpt_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module srpt_queue #(
   parameter int unsigned depth_p = srpt_pkg::queue_depth
) (
   input  wire logic             ap_clk,
   input  wire logic             ap_rst,
   input  wire logic             push_i,
   input  wire srpt_pkg::entry_t push_entry_i,
   output srpt_pkg::entry_t      head_o
);

   import srpt_pkg::*;

   // Stored entries, position 0 is the head
   entry_t store_q [depth_p];

   // Vectors of depth_p+1 entries, index 0 is the pushed position
   entry_t even_c [depth_p+1];
   entry_t odd_c  [depth_p+1];

   // Head as it leaves the compare against the pushed entry
   entry_t top_lower_c;

   // Pushed entry against the current head
   srpt_swap_cell u_top_cell (
      .upper_i (push_entry_i),
      .lower_i (store_q[0]),
      .upper_o (even_c[0]),
      .lower_o (top_lower_c)
   );

   // With no push the head bypasses the top compare
   assign even_c[1] = push_i ? top_lower_c : store_q[0];

   // Even stage over stored pairs (1,2), (3,4) and so on
   for (genvar e = 1; e < depth_p - 1; e += 2) begin : g_even
      srpt_swap_cell u_even_cell (
         .upper_i (store_q[e]),
         .lower_i (store_q[e+1]),
         .upper_o (even_c[e+1]),
         .lower_o (even_c[e+2])
      );
   end

   // Last position has no partner in the even stage
   assign even_c[depth_p] = store_q[depth_p-1];

   // Odd stage, offset by one against the even stage
   assign odd_c[0] = even_c[0];

   for (genvar o = 1; o < depth_p; o += 2) begin : g_odd
      srpt_swap_cell u_odd_cell (
         .upper_i (even_c[o]),
         .lower_i (even_c[o+1]),
         .upper_o (odd_c[o]),
         .lower_o (odd_c[o+1])
      );
   end

   // A push shifts everything down by one and drops the tail
   // Without a push the old entries sort in place
   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         for (int i = 0; i < depth_p; i++) begin
            store_q[i] <= empty_entry;
         end
      end else begin
         for (int i = 0; i < depth_p; i++) begin
            store_q[i] <= push_i ? odd_c[i] : odd_c[i+1];
         end
      end
   end

   assign head_o = store_q[0];

endmodule

`default_nettype wire

// ==== grant/grant_match.sv ====
`timescale 1ns/1ps
`default_nettype none

module grant_match (
   input  wire hdr_pkg::hdr_t                              hdr_i,
   input  wire srpt_pkg::entry_t [srpt_pkg::num_slots-1:0] slots_i,
   input  wire srpt_pkg::entry_t [srpt_pkg::num_slots-1:0] heads_i,
   output logic                                            peer_hit_o,
   output srpt_pkg::slot_idx_t                             peer_slot_o,
   output logic                                            rpc_hit_o,
   output srpt_pkg::slot_idx_t                             rpc_slot_o,
   output logic                                            open_hit_o,
   output srpt_pkg::slot_idx_t                             open_slot_o
);

   import srpt_pkg::*;

   logic [num_slots-1:0] occupied_c;
   logic [num_slots-1:0] peer_eq_c;
   logic [num_slots-1:0] rpc_eq_c;
   logic [num_slots-1:0] open_c;

   // Index of the lowest set bit, zero when none is set
   function automatic slot_idx_t first_set(input logic [num_slots-1:0] vec);
      slot_idx_t idx;
      idx = '0;
      for (int s = num_slots - 1; s >= 0; s--) begin
         if (vec[s]) begin
            idx = slot_idx_t'(s);
         end
      end
      return idx;
   endfunction

   always_comb begin
      for (int s = 0; s < num_slots; s++) begin
         // Free slots keep stale ids, they must not match
         occupied_c[s] = (slots_i[s].prio != prio_empty);
         peer_eq_c[s]  = occupied_c[s] && (slots_i[s].peer == hdr_i.peer);
         rpc_eq_c[s]   = peer_eq_c[s] && (slots_i[s].rpc == hdr_i.rpc);
         // Free slot whose queue offers an eligible RPC
         open_c[s]     = !occupied_c[s] && (heads_i[s].prio == prio_active);
      end
   end

   assign peer_hit_o  = |peer_eq_c;
   assign peer_slot_o = first_set(peer_eq_c);

   assign rpc_hit_o   = |rpc_eq_c;
   assign rpc_slot_o  = first_set(rpc_eq_c);

   // Lowest open slot launches first
   assign open_hit_o  = |open_c;
   assign open_slot_o = first_set(open_c);

endmodule

`default_nettype wire

// ==== grant/grant_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module grant_ctrl (
   input  wire logic                                       ap_clk,
   input  wire logic                                       ap_rst,
   input  wire logic                                       hdr_valid_i,
   input  wire hdr_pkg::hdr_t                              hdr_i,
   output logic                                            hdr_read_o,
   input  wire logic                                       grant_full_i,
   output logic                                            grant_write_o,
   output srpt_pkg::entry_t                                grant_o,
   input  wire srpt_pkg::entry_t [srpt_pkg::num_slots-1:0] heads_i,
   output logic                                            push_o,
   output srpt_pkg::entry_t [srpt_pkg::num_slots-1:0]      push_entries_o
);

   import srpt_pkg::*;

   // Active set, one granted RPC per slot
   entry_t [num_slots-1:0] slots_q;

   logic       peer_hit;
   slot_idx_t  peer_slot;
   logic       rpc_hit;
   slot_idx_t  rpc_slot;
   logic       open_hit;
   slot_idx_t  open_slot;

   // Header decode
   logic       need_c;
   logic       first_c;
   grantable_t hdr_grantable_c;

   // Actions for this cycle
   logic       hdr_first_c;
   logic       hdr_later_c;
   logic       grant_go_c;
   entry_t     launch_c;

   grant_match u_grant_match (
      .hdr_i       (hdr_i),
      .slots_i     (slots_q),
      .heads_i     (heads_i),
      .peer_hit_o  (peer_hit),
      .peer_slot_o (peer_slot),
      .rpc_hit_o   (rpc_hit),
      .rpc_slot_o  (rpc_slot),
      .open_hit_o  (open_hit),
      .open_slot_o (open_slot)
   );

   // Every header is consumed in the cycle it shows up
   assign hdr_read_o = hdr_valid_i;

   assign need_c          = (hdr_i.msg_len > hdr_i.incoming);
   assign first_c         = (hdr_i.offset == '0);
   assign hdr_grantable_c = hdr_i.msg_len - hdr_i.incoming;

   // New message that still needs grants
   assign hdr_first_c = hdr_valid_i && first_c && need_c;
   // Data for an RPC that holds a slot
   assign hdr_later_c = hdr_valid_i && !first_c && rpc_hit;
   // Grants only run in cycles without a header
   assign grant_go_c  = !hdr_valid_i && !grant_full_i && open_hit;

   assign launch_c = heads_i[open_slot];

   // Headers needing no action push nothing
   assign push_o = hdr_first_c || hdr_later_c || grant_go_c;

   // Per-queue entry, only looked at when push_o is high
   always_comb begin
      for (int s = 0; s < num_slots; s++) begin
         if (hdr_valid_i) begin
            push_entries_o[s].peer      = hdr_i.peer;
            push_entries_o[s].rpc       = hdr_i.rpc;
            push_entries_o[s].grantable = hdr_grantable_c;
            if (first_c) begin
               // Peer already granted, eligible only in its own slot
               if (peer_hit && (slot_idx_t'(s) != peer_slot)) begin
                  push_entries_o[s].prio = prio_blocked;
               end else begin
                  push_entries_o[s].prio = prio_active;
               end
            end else begin
               // Complete message leaves every queue
               push_entries_o[s].prio = need_c ? prio_unblock : prio_invalidate;
            end
         end else begin
            push_entries_o[s].peer      = launch_c.peer;
            push_entries_o[s].rpc       = launch_c.rpc;
            push_entries_o[s].grantable = launch_c.grantable;
            // Own queue keeps it active, the others block the peer
            if (slot_idx_t'(s) == open_slot) begin
               push_entries_o[s].prio = prio_update;
            end else begin
               push_entries_o[s].prio = prio_update_block;
            end
         end
      end
   end

   // Active set changes on the same edge as the queues
   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         for (int s = 0; s < num_slots; s++) begin
            slots_q[s] <= empty_entry;
         end
         grant_write_o <= 1'b0;
         grant_o       <= '0;
      end else begin
         grant_write_o <= grant_go_c;
         if (grant_go_c) begin
            grant_o            <= launch_c;
            slots_q[open_slot] <= launch_c;
         end
         // Slot frees up once its RPC sends more data
         if (hdr_later_c) begin
            slots_q[rpc_slot].prio <= prio_empty;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/srpt_grant_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module srpt_grant_top (
   input  wire logic          ap_clk,
   input  wire logic          ap_rst,
   input  wire logic          hdr_valid_i,
   input  wire hdr_pkg::hdr_t hdr_i,
   output logic               hdr_read_o,
   input  wire logic          grant_full_i,
   output logic               grant_write_o,
   output srpt_pkg::entry_t   grant_o
);

   import srpt_pkg::*;

   // Shared push strobe, one entry per queue
   logic                        push;
   entry_t [num_slots-1:0]      push_entries;

   // Queue heads back to the controller
   wire entry_t [num_slots-1:0] heads;

   grant_ctrl u_grant_ctrl (
      .ap_clk         (ap_clk),
      .ap_rst         (ap_rst),
      .hdr_valid_i    (hdr_valid_i),
      .hdr_i          (hdr_i),
      .hdr_read_o     (hdr_read_o),
      .grant_full_i   (grant_full_i),
      .grant_write_o  (grant_write_o),
      .grant_o        (grant_o),
      .heads_i        (heads),
      .push_o         (push),
      .push_entries_o (push_entries)
   );

   // One sorted queue behind each active-set slot
   for (genvar s = 0; s < num_slots; s++) begin : g_queue
      srpt_queue #(
         .depth_p (queue_depth)
      ) u_srpt_queue (
         .ap_clk       (ap_clk),
         .ap_rst       (ap_rst),
         .push_i       (push),
         .push_entry_i (push_entries[s]),
         .head_o       (heads[s])
      );
   end

endmodule

`default_nettype wire

// ==== bench/srpt_grant_model.svh ====
`ifndef SRPT_GRANT_MODEL_SVH
`define SRPT_GRANT_MODEL_SVH

// Reference state, one array per queue plus the active set
entry_t m_store [num_slots][queue_depth];
entry_t m_slots [num_slots];
logic   m_grant_write;
entry_t m_grant;

// Rank test, then the command of the upper entry rewrites what it passes
function automatic void compare_swap(input entry_t u, input entry_t l,
                                     output entry_t nu, output entry_t nl);
   logic below;
   below = (u.prio == l.prio) ? (u.grantable > l.grantable) : (u.prio < l.prio);
   nu = u;
   nl = l;
   if (below) begin
      nl = u;
      nu = l;
      if (u.peer == l.peer) begin
         if (u.prio == prio_update_block) begin
            nu.prio = prio_blocked;
            // Only the granted RPC itself takes the new byte count
            if (u.rpc == l.rpc) begin
               nu.grantable = u.grantable;
            end
         end else if (u.prio == prio_unblock) begin
            nu.prio = prio_active;
         end else if ((u.prio == prio_invalidate) && (u.rpc == l.rpc)) begin
            nu.prio = prio_empty;
         end
      end
   end
endfunction

// One queue step, a push widens the vector by one at the top
// The two passes swap their pairings when there is no push
function automatic void queue_step(input int q, input logic push, input entry_t pe);
   entry_t v [queue_depth+1];
   int     n;
   int     start;
   if (push) begin
      v[0] = pe;
      for (int i = 0; i < queue_depth; i++) begin
         v[i+1] = m_store[q][i];
      end
      n = queue_depth + 1;
      start = 0;
   end else begin
      for (int i = 0; i < queue_depth; i++) begin
         v[i] = m_store[q][i];
      end
      n = queue_depth;
      start = 1;
   end
   for (int i = start; i + 1 < n; i += 2) begin
      compare_swap(v[i], v[i+1], v[i], v[i+1]);
   end
   for (int i = 1 - start; i + 1 < n; i += 2) begin
      compare_swap(v[i], v[i+1], v[i], v[i+1]);
   end
   // Anything past the last position falls off
   for (int i = 0; i < queue_depth; i++) begin
      m_store[q][i] = v[i];
   end
endfunction

function automatic void model_reset();
   for (int s = 0; s < num_slots; s++) begin
      m_slots[s] = empty_entry;
      for (int i = 0; i < queue_depth; i++) begin
         m_store[s][i] = empty_entry;
      end
   end
   m_grant_write = 1'b0;
   m_grant = '0;
endfunction

// Advances the model across one rising edge with the inputs seen there
function automatic void model_step(input logic valid, input hdr_t h, input logic full);
   logic   need;
   logic   first;
   logic   peer_hit;
   logic   rpc_hit;
   logic   open_hit;
   logic   push;
   int     peer_s;
   int     rpc_s;
   int     open_s;
   entry_t head;
   entry_t pe [num_slots];
   need = (h.msg_len > h.incoming);
   first = (h.offset == 32'd0);
   peer_hit = 1'b0;
   rpc_hit = 1'b0;
   open_hit = 1'b0;
   push = 1'b0;
   peer_s = 0;
   rpc_s = 0;
   open_s = 0;
   // Walk downward so that the lowest matching slot is kept
   for (int s = num_slots - 1; s >= 0; s--) begin
      if ((m_slots[s].prio != prio_empty) && (m_slots[s].peer == h.peer)) begin
         peer_hit = 1'b1;
         peer_s = s;
         if (m_slots[s].rpc == h.rpc) begin
            rpc_hit = 1'b1;
            rpc_s = s;
         end
      end
      if ((m_slots[s].prio == prio_empty) && (m_store[s][0].prio == prio_active)) begin
         open_hit = 1'b1;
         open_s = s;
      end
   end
   m_grant_write = 1'b0;
   if (valid && first && need) begin
      push = 1'b1;
      for (int s = 0; s < num_slots; s++) begin
         pe[s] = '{peer: h.peer, rpc: h.rpc, grantable: grantable_t'(h.msg_len - h.incoming),
                   prio: (peer_hit && (s != peer_s)) ? prio_blocked : prio_active};
      end
   end else if (valid && !first && rpc_hit) begin
      push = 1'b1;
      for (int s = 0; s < num_slots; s++) begin
         pe[s] = '{peer: h.peer, rpc: h.rpc, grantable: grantable_t'(h.msg_len - h.incoming),
                   prio: need ? prio_unblock : prio_invalidate};
      end
      m_slots[rpc_s].prio = prio_empty;
   end else if (!valid && !full && open_hit) begin
      head = m_store[open_s][0];
      push = 1'b1;
      for (int s = 0; s < num_slots; s++) begin
         pe[s] = '{peer: head.peer, rpc: head.rpc, grantable: head.grantable,
                   prio: (s == open_s) ? prio_update : prio_update_block};
      end
      m_grant_write = 1'b1;
      m_grant = head;
      m_slots[open_s] = head;
   end
   for (int s = 0; s < num_slots; s++) begin
      queue_step(s, push, pe[s]);
   end
endfunction

`endif

// ==== bench/tb_srpt_grant.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_srpt_grant;

   import srpt_pkg::*;
   import hdr_pkg::*;

   localparam int clk_period_ns   = 20;
   localparam int reset_cycles    = 8;
   localparam int random_cycles   = 3000;
   // Rough length of the directed tests together
   localparam int directed_cycles = 30 + 50 + 50 + 120 + 70;
   localparam int watchdog_cycles = 6 * (reset_cycles + 2) + directed_cycles
                                    + random_cycles + 500;

   logic        ap_clk;
   logic        ap_rst;
   logic        hdr_valid_i;
   hdr_t        hdr_i;
   logic        hdr_read_o;
   logic        grant_full_i;
   logic        grant_write_o;
   entry_t      grant_o;

   int          error_count = 0;
   int          failed_tests = 0;
   logic [31:0] rng_state = 32'd90508;
   // Grants observed since the last reset, oldest first
   entry_t      grants_seen [$];

   `include "srpt_grant_model.svh"

   srpt_grant_top u_srpt_grant_top (
      .ap_clk        (ap_clk),
      .ap_rst        (ap_rst),
      .hdr_valid_i   (hdr_valid_i),
      .hdr_i         (hdr_i),
      .hdr_read_o    (hdr_read_o),
      .grant_full_i  (grant_full_i),
      .grant_write_o (grant_write_o),
      .grant_o       (grant_o)
   );

   initial begin
      ap_clk = 1'b0;
      forever #(clk_period_ns / 2) ap_clk = ~ap_clk;
   end

   initial begin
      #(watchdog_cycles * clk_period_ns);
      $display("watchdog expired before the tests completed");
      $display("TESTBENCH FAILED");
      $finish;
   end

   // Mid-cycle compare, then the model takes the coming edge
   always @(negedge ap_clk) begin
      assert (hdr_read_o == hdr_valid_i) else begin
         $display("mismatch hdr_read_o: got %h expected %h", hdr_read_o, hdr_valid_i);
         error_count++;
      end
      if (ap_rst) begin
         model_reset();
      end else begin
         assert (grant_write_o == m_grant_write) else begin
            $display("mismatch grant_write_o: got %h expected %h", grant_write_o, m_grant_write);
            error_count++;
         end
         assert (grant_o == m_grant) else begin
            $display("mismatch grant_o: got %h expected %h", grant_o, m_grant);
            error_count++;
         end
         if (grant_write_o) begin
            grants_seen.push_back(grant_o);
         end
         model_step(hdr_valid_i, hdr_i, grant_full_i);
      end
   end

   // 32-bit xorshift
   function automatic logic [31:0] rand_next();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic hdr_t make_hdr(input peer_id_t peer, input rpc_id_t rpc,
                                     input msg_len_t msg_len, input msg_len_t incoming,
                                     input logic [31:0] offset);
      return '{peer: peer, rpc: rpc, msg_len: msg_len, incoming: incoming, offset: offset};
   endfunction

   task automatic reset_dut();
      @(posedge ap_clk);
      ap_rst       <= 1'b1;
      hdr_valid_i  <= 1'b0;
      grant_full_i <= 1'b0;
      repeat (reset_cycles) @(posedge ap_clk);
      ap_rst <= 1'b0;
      grants_seen.delete();
   endtask

   task automatic drive_header(input hdr_t h);
      @(posedge ap_clk);
      hdr_valid_i <= 1'b1;
      hdr_i       <= h;
   endtask

   task automatic drive_idle();
      @(posedge ap_clk);
      hdr_valid_i <= 1'b0;
   endtask

   task automatic drive_random();
      logic [31:0] r;
      logic [31:0] s;
      msg_len_t    len;
      msg_len_t    inc;
      r = rand_next();
      s = rand_next();
      len = s[9:0];
      // About a quarter of the headers have nothing left to grant
      inc = (s[11:10] == 2'b00) ? len : msg_len_t'(s[19:12]);
      @(posedge ap_clk);
      hdr_valid_i  <= (r[10:8] < 3'd3);
      grant_full_i <= (r[3:2] == 2'b00);
      // Small pools so that slot matches happen often
      hdr_i <= make_hdr(peer_id_t'(r[5:4]), rpc_id_t'(r[7:6]), len, inc,
                        r[1] ? 32'd0 : {s[31:20], 20'd1});
   endtask

   // Waited is the number of edges spent in the loop
   task automatic wait_grants(input int count, input int limit, output int waited);
      waited = 0;
      while ((grants_seen.size() < count) && (waited < limit)) begin
         @(posedge ap_clk);
         waited++;
      end
      assert (grants_seen.size() >= count) else begin
         $display("timed out after %0d cycles waiting for grant number %0d", limit, count);
         error_count++;
      end
   endtask

   task automatic wait_peer_grant(input peer_id_t peer, input int limit);
      int  waited;
      logic seen;
      waited = 0;
      seen = 1'b0;
      while (!seen && (waited < limit)) begin
         @(posedge ap_clk);
         waited++;
         foreach (grants_seen[i]) begin
            seen |= (grants_seen[i].peer == peer);
         end
      end
      assert (seen) else begin
         $display("timed out after %0d cycles waiting for a grant to peer %h", limit, peer);
         error_count++;
      end
   endtask

   task automatic finish_test(input int num, input string name, input int errors_at_start);
      int errs;
      errs = error_count - errors_at_start;
      if (errs != 0) begin
         failed_tests++;
      end
      $display("test %0d %s: %s, %0d errors", num, name, (errs == 0) ? "ok" : "failed", errs);
   endtask

   initial begin
      int     start;
      int     waited;
      entry_t expected;
      ap_rst       = 1'b1;
      hdr_valid_i  = 1'b0;
      hdr_i        = '0;
      grant_full_i = 1'b0;

      // Idle, then headers that must not push anything
      reset_dut();
      start = error_count;
      repeat (4) drive_idle();
      drive_header(make_hdr(40, 1, 100, 0, 32'd512));
      drive_header(make_hdr(41, 2, 50, 50, 32'd0));
      repeat (10) drive_idle();
      assert (grants_seen.size() == 0) else begin
         $display("grant written although no header asked for one");
         error_count++;
      end
      finish_test(1, "idle", start);

      // Single first packet, latency counted from the driving edge
      reset_dut();
      start = error_count;
      drive_header(make_hdr(1, 1, 100, 20, 32'd0));
      drive_idle();
      wait_grants(1, 20, waited);
      assert (waited + 1 == 3) else begin
         $display("mismatch grant latency: got %h expected %h", waited + 1, 3);
         error_count++;
      end
      expected = '{peer: 14'd1, rpc: 14'd1, grantable: 10'd80, prio: prio_active};
      assert (grants_seen[0] == expected) else begin
         $display("mismatch grant_o: got %h expected %h", grants_seen[0], expected);
         error_count++;
      end
      repeat (10) drive_idle();
      assert (grants_seen.size() == 1) else begin
         $display("more than one grant for a single header");
         error_count++;
      end
      finish_test(2, "single grant", start);

      // Four peers, smallest message first
      reset_dut();
      start = error_count;
      drive_header(make_hdr(10, 1, 300, 0, 32'd0));
      drive_header(make_hdr(11, 1, 120, 0, 32'd0));
      drive_header(make_hdr(12, 1, 450, 0, 32'd0));
      drive_header(make_hdr(13, 1, 200, 0, 32'd0));
      drive_idle();
      wait_grants(4, 30, waited);
      assert (grants_seen[0].grantable == 10'd120) else begin
         $display("mismatch grant_o.grantable: got %h expected %h",
                  grants_seen[0].grantable, 10'd120);
         error_count++;
      end
      finish_test(3, "four peers", start);

      // Two RPCs of one peer share a single slot
      reset_dut();
      start = error_count;
      drive_header(make_hdr(5, 1, 50, 0, 32'd0));
      drive_header(make_hdr(5, 2, 30, 0, 32'd0));
      drive_idle();
      wait_grants(1, 20, waited);
      repeat (10) drive_idle();
      assert ((grants_seen.size() == 1) && (grants_seen[0].rpc == 14'd2)) else begin
         $display("peer 5 was not granted exactly once for its shorter RPC");
         error_count++;
      end
      drive_header(make_hdr(5, 2, 30, 10, 32'd64));
      drive_idle();
      wait_grants(2, 20, waited);
      assert (grants_seen[1].peer == 14'd5) else begin
         $display("mismatch grant_o.peer: got %h expected %h", grants_seen[1].peer, 14'd5);
         error_count++;
      end
      // Completing packet, then a new peer competes for the freed slot
      drive_header(make_hdr(5, 2, 30, 30, 32'd128));
      drive_header(make_hdr(9, 3, 200, 0, 32'd0));
      drive_idle();
      wait_peer_grant(9, 40);
      finish_test(4, "one peer two rpcs", start);

      // Back-pressure from the grant FIFO
      reset_dut();
      start = error_count;
      drive_header(make_hdr(20, 1, 90, 0, 32'd0));
      grant_full_i <= 1'b1;
      drive_header(make_hdr(21, 1, 60, 0, 32'd0));
      repeat (20) drive_idle();
      assert (grants_seen.size() == 0) else begin
         $display("grant written while the grant FIFO was full");
         error_count++;
      end
      drive_idle();
      grant_full_i <= 1'b0;
      wait_grants(2, 20, waited);
      finish_test(5, "back-pressure", start);

      // Long random run against the model
      reset_dut();
      start = error_count;
      for (int i = 0; i < random_cycles; i++) begin
         drive_random();
      end
      drive_idle();
      grant_full_i <= 1'b0;
      repeat (40) drive_idle();
      finish_test(6, "random", start);

      $display("tests 6, failed tests %0d, failed checks %0d", failed_tests, error_count);
      if (error_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+bench
common/srpt_pkg.sv
common/hdr_pkg.sv
srpt_queue/srpt_swap_cell.sv
srpt_queue/srpt_queue.sv
grant/grant_match.sv
grant/grant_ctrl.sv
source/srpt_grant_top.sv
bench/tb_srpt_grant.sv

// ==== Bender.yml ====
package:
  name: srpt_grant

sources:
  - common/srpt_pkg.sv
  - common/hdr_pkg.sv
  - srpt_queue/srpt_swap_cell.sv
  - srpt_queue/srpt_queue.sv
  - grant/grant_match.sv
  - grant/grant_ctrl.sv
  - source/srpt_grant_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_srpt_grant.sv
